//--- list.f
+incdir+bench
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/mips_fetch.sv
hdl/mips_decode.sv
hdl/mips_regfile.sv
hdl/mips_execute.sv
hdl/mips_result.sv
hdl/mips_cpu_harvard.sv
bench/mips_cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build the MIPS CPU testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module mips_cpu_tb -f list.f -o mips_cpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "FAIL: Verilator build returned status $status"
  exit 1
fi

./obj_dir/mips_cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "FAIL: simulation returned status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL: pass line not found in $LOG"
  exit 1
fi

//--- bench/mips_test_programs.svh
`ifndef MIPS_TEST_PROGRAMS_SVH
`define MIPS_TEST_PROGRAMS_SVH

localparam int NUM_TESTS = 9;
localparam int MAX_WORDS = 16;

// Register numbers used by the programs
localparam reg_idx_t ZERO = 5'd0;
localparam reg_idx_t V0   = 5'd2;
localparam reg_idx_t T0   = 5'd8;
localparam reg_idx_t T1   = 5'd9;
localparam reg_idx_t T2   = 5'd10;
localparam reg_idx_t T3   = 5'd11;
localparam reg_idx_t T4   = 5'd12;
localparam reg_idx_t T5   = 5'd13;
localparam reg_idx_t T6   = 5'd14;
localparam reg_idx_t RA   = 5'd31;

localparam word_t NOP     = 32'h0000_0000;
localparam word_t JR_ZERO = {OP_SPECIAL, 20'h00000, FN_JR};

// One row per program with code, expected v0 and checked data word
string test_name  [NUM_TESTS];
word_t test_code  [NUM_TESTS][MAX_WORDS];
int    test_len   [NUM_TESTS];
word_t test_v0    [NUM_TESTS];
word_t test_addr  [NUM_TESTS];
word_t test_word  [NUM_TESTS];
bit    test_stall [NUM_TESTS];
int    fill_index;

task automatic start_test(input int t, input string name, input word_t v0,
                          input word_t addr, input word_t word, input bit stall);
  fill_index    = t;
  test_name[t]  = name;
  test_len[t]   = 0;
  test_v0[t]    = v0;
  test_addr[t]  = addr;
  test_word[t]  = word;
  test_stall[t] = stall;
endtask

task automatic emit(input word_t instr);
  test_code[fill_index][test_len[fill_index]] = instr;
  test_len[fill_index]++;
endtask

// Skipped words add large constants so any leak shows in v0
task automatic jump_program();
  emit(j_word(OP_J, rom_address(4)));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0001));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0100));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0200));
  emit(j_word(OP_JAL, rom_address(8)));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0002));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0400));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0800));
  emit(i_word(OP_SW, ZERO, RA, 16'h0100));
  emit(JR_ZERO);
  emit(i_word(OP_ADDIU, V0, V0, 16'h0004));
endtask

task automatic build_tests();
  start_test(0, "alu", 32'h1234_5677, 32'h20, 32'h0000_0e1f, 1'b0);
  emit(i_word(OP_LUI, ZERO, T0, 16'h1234));
  emit(i_word(OP_ORI, T0, T0, 16'h5678));
  emit(i_word(OP_ADDIU, ZERO, T1, 16'hffff));
  emit(r_word(T0, T1, V0, 5'd0, FN_ADDU));
  emit(i_word(OP_ORI, ZERO, T2, 16'h0ff0));
  emit(i_word(OP_ORI, ZERO, T3, 16'h00ff));
  emit(r_word(T2, T3, T4, 5'd0, FN_AND));
  emit(r_word(T2, T3, T5, 5'd0, FN_XOR));
  emit(r_word(T5, T4, T6, 5'd0, FN_SUBU));
  emit(i_word(OP_SW, ZERO, T6, 16'h0020));
  emit(JR_ZERO);
  emit(NOP);

  // Signed and unsigned compares of -5 against 3
  start_test(1, "compare", 32'h0000_0006, 32'h24, 32'h0000_0001, 1'b0);
  emit(i_word(OP_ADDIU, ZERO, T0, 16'hfffb));
  emit(i_word(OP_ADDIU, ZERO, T1, 16'h0003));
  emit(r_word(T0, T1, T2, 5'd0, FN_SLT));
  emit(r_word(T0, T1, T3, 5'd0, FN_SLTU));
  emit(r_word(T1, T0, T4, 5'd0, FN_SLTU));
  emit(r_word(ZERO, T2, T2, 5'd1, FN_SLL));
  emit(r_word(ZERO, T4, T4, 5'd2, FN_SLL));
  emit(r_word(T2, T3, V0, 5'd0, FN_OR));
  emit(r_word(V0, T4, V0, 5'd0, FN_OR));
  emit(i_word(OP_SLTI, T0, T5, 16'hfffc));
  emit(i_word(OP_SW, ZERO, T5, 16'h0024));
  emit(JR_ZERO);
  emit(NOP);

  start_test(2, "shifts", 32'h0800_0101, 32'h40, 32'hf800_0001, 1'b0);
  emit(i_word(OP_LUI, ZERO, T0, 16'h8000));
  emit(i_word(OP_ORI, T0, T0, 16'h0010));
  emit(r_word(ZERO, T0, T1, 5'd4, FN_SLL));
  emit(r_word(ZERO, T0, T2, 5'd4, FN_SRL));
  emit(r_word(ZERO, T0, T3, 5'd4, FN_SRA));
  emit(r_word(T1, T2, V0, 5'd0, FN_OR));
  emit(i_word(OP_SW, ZERO, T3, 16'h0040));
  emit(JR_ZERO);
  emit(NOP);

  // Byte 0xaa lands in lane 1 of the stored word
  start_test(3, "store", 32'h11aa_3344, 32'h80, 32'h11aa_3344, 1'b0);
  emit(i_word(OP_LUI, ZERO, T0, 16'h1122));
  emit(i_word(OP_ORI, T0, T0, 16'h3344));
  emit(i_word(OP_SW, ZERO, T0, 16'h0080));
  emit(i_word(OP_ADDIU, ZERO, T1, 16'h00aa));
  emit(i_word(OP_SB, ZERO, T1, 16'h0081));
  emit(i_word(OP_LW, ZERO, V0, 16'h0080));
  emit(JR_ZERO);
  emit(NOP);

  start_test(4, "load_byte", 32'hffff_ff00, 32'hc4, 32'hffff_ff85, 1'b0);
  emit(i_word(OP_LUI, ZERO, T0, 16'h0085));
  emit(i_word(OP_ORI, T0, T0, 16'h7f00));
  emit(i_word(OP_SW, ZERO, T0, 16'h00c0));
  emit(i_word(OP_LB, ZERO, T1, 16'h00c1));
  emit(i_word(OP_LBU, ZERO, T2, 16'h00c1));
  emit(r_word(T1, T2, V0, 5'd0, FN_XOR));
  emit(i_word(OP_SW, ZERO, T1, 16'h00c4));
  emit(JR_ZERO);
  emit(NOP);

  // Each executed step adds its own bit to v0
  start_test(5, "branches", 32'h0000_003f, 32'h0, 32'h0, 1'b0);
  emit(i_word(OP_ADDIU, ZERO, T0, 16'h0001));
  emit(i_word(OP_BEQ, T0, ZERO, 16'h0002));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0001));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0002));
  emit(i_word(OP_BNE, T0, ZERO, 16'h0002));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0004));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0100));
  emit(i_word(OP_BEQ, T0, T0, 16'h0002));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0008));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0200));
  emit(i_word(OP_BNE, T0, T0, 16'h0002));
  emit(i_word(OP_ADDIU, V0, V0, 16'h0010));
  emit(JR_ZERO);
  emit(i_word(OP_ADDIU, V0, V0, 16'h0020));

  // jal sits at word 4, so ra is the reset vector plus 0x18
  start_test(6, "jumps", 32'h0000_0007, 32'h100, 32'hbfc0_0018, 1'b0);
  jump_program();

  start_test(7, "multiply", 32'h0000_0001, 32'h140, 32'hffff_fffe, 1'b0);
  emit(i_word(OP_ADDIU, ZERO, T0, 16'hffff));
  emit(i_word(OP_ADDIU, ZERO, T1, 16'h0002));
  emit(r_word(T0, T1, ZERO, 5'd0, FN_MULTU));
  emit(r_word(ZERO, ZERO, V0, 5'd0, FN_MFHI));
  emit(r_word(ZERO, ZERO, T3, 5'd0, FN_MFLO));
  emit(i_word(OP_SW, ZERO, T3, 16'h0140));
  emit(JR_ZERO);
  emit(NOP);

  start_test(8, "jumps_stalled", 32'h0000_0007, 32'h100, 32'hbfc0_0018, 1'b1);
  jump_program();
endtask

`endif

//--- bench/mips_cpu_tb.sv
module mips_cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mips_isa_pkg::*;

  localparam int ROM_WORDS = 16;
  localparam int RAM_WORDS = 256;

  logic  clk;
  logic  reset;
  logic  clk_enable;
  logic  active;
  word_t register_v0;
  word_t instr_address;
  word_t instr_readdata;
  word_t data_address;
  logic  data_write;
  logic  data_read;
  word_t data_writedata;
  word_t data_readdata;

  word_t rom [ROM_WORDS];
  word_t ram [RAM_WORDS];
  word_t rom_index;
  int    cycle_count = 0;
  int    seed;

  // Instruction encoders for the test programs
  function automatic word_t r_word(input reg_idx_t rs, input reg_idx_t rt,
                                   input reg_idx_t rd, input shamt_t sa, input funct_t fn);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
  endfunction

  function automatic word_t i_word(input opcode_t op, input reg_idx_t rs,
                                   input reg_idx_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_word(input opcode_t op, input word_t target);
    return {op, target[27:2]};
  endfunction

  function automatic word_t rom_address(input int idx);
    return RESET_VECTOR + word_t'(idx * 4);
  endfunction

  `include "mips_test_programs.svh"

  localparam int CYCLE_LIMIT = 64 * NUM_TESTS;

  mips_cpu_harvard uut (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Program sits at the reset vector and other addresses read as nop
  assign rom_index      = (instr_address - RESET_VECTOR) >> 2;
  assign instr_readdata = (rom_index < ROM_WORDS) ? rom[rom_index[3:0]] : '0;

  // Marker word unless the CPU asserts data_read
  assign data_readdata = data_read ? ram[data_address[9:2]] : 32'hdead_beef;

  always @(posedge clk) begin
    if (data_write) begin
      if (data_address[31:10] != '0) begin
        $display("Data write to address %h lies outside the data RAM", data_address);
        $display("Test failed");
        $fatal(1, "data write out of range");
      end else begin
        ram[data_address[9:2]] <= data_writedata;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: programs still running after %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_value(input string what, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", what, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch in %s", what);
    end
  endtask

  task automatic load_program(input int t);
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = (i < test_len[t]) ? test_code[t][i] : NOP;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram[i] = '0;
    end
  endtask

  task automatic apply_reset();
    reset      = 1'b1;
    clk_enable = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic run_test(input int t);
    load_program(t);
    apply_reset();
    // One cycle at a time until the jump to address 0 retires
    while (active) begin
      @(posedge clk);
      #1;
      if (test_stall[t]) begin
        clk_enable = ($random(seed) & 3) != 0;
      end
    end
    clk_enable = 1'b1;
    check_value({test_name[t], " v0"}, test_v0[t], register_v0);
    check_value({test_name[t], " memory"}, test_word[t], ram[test_addr[t][9:2]]);
    // Halted CPU keeps its state
    repeat (2) @(posedge clk);
    #1;
    check_value({test_name[t], " v0 after halt"}, test_v0[t], register_v0);
    check_value({test_name[t], " active after halt"}, 32'h0, {31'b0, active});
  endtask

  initial begin
    reset      = 1'b1;
    clk_enable = 1'b1;
    seed       = 3;
    build_tests();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- hdl/mips_cpu_harvard.sv
module mips_cpu_harvard (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,

  input  logic        clk_enable,

  // Instruction port read combinationally
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,

  // Data port with combinational read and write on the clock edge
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  alu_op_t   alu_op;
  wb_sel_t   wb_sel;
  mem_size_t mem_size;
  pc_sel_t   pc_sel;
  logic      alu_src_imm;
  logic      reg_write;
  logic      mem_read;
  logic      mem_write;
  logic      hilo_write;
  logic      redirect;
  logic      running;
  reg_idx_t  dest_reg;
  reg_idx_t  rs_idx;
  reg_idx_t  rt_idx;
  shamt_t    shamt;
  word_t     imm_ext;
  word_t     rs_value;
  word_t     rt_value;
  word_t     alu_result;
  word_t     redirect_target;
  word_t     hi;
  word_t     lo;
  word_t     write_data;

  // No state is committed while in reset or after the halt
  assign running = active && !reset;

  mips_fetch fetch (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .redirect   (redirect),
    .target     (redirect_target),
    .pc         (instr_address),
    .active     (active)
  );

  mips_decode decode (
    .instr       (instr_readdata),
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .reg_write   (reg_write),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .hilo_write  (hilo_write),
    .wb_sel      (wb_sel),
    .mem_size    (mem_size),
    .pc_sel      (pc_sel),
    .dest_reg    (dest_reg),
    .rs_idx      (rs_idx),
    .rt_idx      (rt_idx),
    .shamt       (shamt),
    .imm_ext     (imm_ext)
  );

  mips_regfile regfile (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .write_en    (reg_write && running),
    .rs_idx      (rs_idx),
    .rt_idx      (rt_idx),
    .write_idx   (dest_reg),
    .write_data  (write_data),
    .rs_value    (rs_value),
    .rt_value    (rt_value),
    .register_v0 (register_v0)
  );

  mips_execute execute (
    .clk             (clk),
    .reset           (reset),
    .clk_enable      (clk_enable),
    .alu_op          (alu_op),
    .alu_src_imm     (alu_src_imm),
    .hilo_write      (hilo_write && running),
    .pc_sel          (pc_sel),
    .shamt           (shamt),
    .rs_value        (rs_value),
    .rt_value        (rt_value),
    .imm_ext         (imm_ext),
    .pc              (instr_address),
    .instr           (instr_readdata),
    .alu_result      (alu_result),
    .redirect_target (redirect_target),
    .hi              (hi),
    .lo              (lo),
    .redirect        (redirect)
  );

  mips_result result (
    .wb_sel         (wb_sel),
    .mem_size       (mem_size),
    .mem_write      (mem_write),
    .alu_result     (alu_result),
    .data_readdata  (data_readdata),
    .rt_value       (rt_value),
    .pc             (instr_address),
    .hi             (hi),
    .lo             (lo),
    .write_data     (write_data),
    .data_writedata (data_writedata)
  );

  assign data_address = alu_result;
  assign data_read    = mem_read;
  assign data_write   = mem_write && clk_enable && running;

  // Unaligned accesses are outside the supported subset
  word_store_aligned: assert property (
    @(posedge clk) (data_write && mem_size == MEM_WORD) |-> (data_address[1:0] == 2'b00)
  ) else $error("cpu: word store to unaligned address %h", data_address);

endmodule

//--- hdl/mips_result.sv
module mips_result (
  input  mips_ctrl_pkg::wb_sel_t   wb_sel,
  input  mips_ctrl_pkg::mem_size_t mem_size,
  input  logic                     mem_write,
  input  mips_isa_pkg::word_t      alu_result,
  input  mips_isa_pkg::word_t      data_readdata,
  input  mips_isa_pkg::word_t      rt_value,
  input  mips_isa_pkg::word_t      pc,
  input  mips_isa_pkg::word_t      hi,
  input  mips_isa_pkg::word_t      lo,
  output mips_isa_pkg::word_t      write_data,
  output mips_isa_pkg::word_t      data_writedata
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  logic [1:0] lane;
  logic [7:0] load_byte;
  word_t      load_value;
  word_t      store_word;

  assign lane = alu_result[1:0];

  // Big-endian lane order puts lane 0 in the top byte
  always_comb begin
    case (lane)
      2'd0:    load_byte = data_readdata[31:24];
      2'd1:    load_byte = data_readdata[23:16];
      2'd2:    load_byte = data_readdata[15:8];
      default: load_byte = data_readdata[7:0];
    endcase
  end

  always_comb begin
    case (mem_size)
      MEM_BYTE_S: load_value = {{24{load_byte[7]}}, load_byte};
      MEM_BYTE_U: load_value = {24'h000000, load_byte};
      default:    load_value = data_readdata;
    endcase
  end

  // sb rewrites a single lane of the word just read
  always_comb begin
    store_word = data_readdata;
    if (mem_size == MEM_WORD) begin
      store_word = rt_value;
    end else begin
      case (lane)
        2'd0:    store_word[31:24] = rt_value[7:0];
        2'd1:    store_word[23:16] = rt_value[7:0];
        2'd2:    store_word[15:8]  = rt_value[7:0];
        default: store_word[7:0]   = rt_value[7:0];
      endcase
    end
  end

  assign data_writedata = mem_write ? store_word : '0;

  always_comb begin
    case (wb_sel)
      WB_LOAD: write_data = load_value;
      WB_LINK: write_data = pc + 32'd8;
      WB_HI:   write_data = hi;
      WB_LO:   write_data = lo;
      default: write_data = alu_result;
    endcase
  end

endmodule

//--- hdl/mips_execute.sv
module mips_execute (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clk_enable,
  input  mips_ctrl_pkg::alu_op_t  alu_op,
  input  logic                    alu_src_imm,
  input  logic                    hilo_write,
  input  mips_ctrl_pkg::pc_sel_t  pc_sel,
  input  mips_isa_pkg::shamt_t    shamt,
  input  mips_isa_pkg::word_t     rs_value,
  input  mips_isa_pkg::word_t     rt_value,
  input  mips_isa_pkg::word_t     imm_ext,
  input  mips_isa_pkg::word_t     pc,
  input  mips_isa_pkg::word_t     instr,
  output mips_isa_pkg::word_t     alu_result,
  output mips_isa_pkg::word_t     redirect_target,
  output mips_isa_pkg::word_t     hi,
  output mips_isa_pkg::word_t     lo,
  output logic                    redirect
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  word_t       operand_b;
  word_t       pc_plus4;
  word_t       branch_target;
  word_t       jump_target;
  opcode_t     opcode;
  logic        regs_equal;
  logic        branch_taken;
  logic [63:0] product;

  assign operand_b = alu_src_imm ? imm_ext : rt_value;
  assign opcode    = instr[31:26];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = rs_value + operand_b;
      ALU_SUB:  alu_result = rs_value - operand_b;
      ALU_AND:  alu_result = rs_value & operand_b;
      ALU_OR:   alu_result = rs_value | operand_b;
      ALU_XOR:  alu_result = rs_value ^ operand_b;
      ALU_SLT:  alu_result = {31'b0, $signed(rs_value) < $signed(operand_b)};
      ALU_SLTU: alu_result = {31'b0, rs_value < operand_b};
      // Shifts take rt and the shamt field
      ALU_SLL:  alu_result = rt_value << shamt;
      ALU_SRL:  alu_result = rt_value >> shamt;
      ALU_SRA:  alu_result = word_t'($signed(rt_value) >>> shamt);
      ALU_LUI:  alu_result = {operand_b[15:0], 16'h0000};
      default:  alu_result = '0;
    endcase
  end

  // Branch offsets count from the delay slot
  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};

  assign regs_equal   = (rs_value == rt_value);
  assign branch_taken = (opcode == OP_BNE) ? !regs_equal : regs_equal;

  always_comb begin
    case (pc_sel)
      PC_BRANCH: begin
        redirect        = branch_taken;
        redirect_target = branch_target;
      end
      PC_JUMP: begin
        redirect        = 1'b1;
        redirect_target = jump_target;
      end
      PC_JREG: begin
        redirect        = 1'b1;
        redirect_target = rs_value;
      end
      default: begin
        redirect        = 1'b0;
        redirect_target = pc_plus4;
      end
    endcase
  end

  assign product = {32'h0, rs_value} * {32'h0, rt_value};

  always_ff @(posedge clk) begin
    if (reset) begin
      hi <= '0;
      lo <= '0;
    end else if (clk_enable && hilo_write) begin
      hi <= product[63:32];
      lo <= product[31:0];
    end
  end

  // Branch decision only knows beq and bne
  branch_opcode: assert property (
    @(posedge clk) disable iff (reset)
    (pc_sel == PC_BRANCH) |-> (opcode == OP_BEQ || opcode == OP_BNE)
  ) else $error("execute: branch select for opcode %h", opcode);

endmodule

//--- hdl/mips_regfile.sv
module mips_regfile (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clk_enable,
  input  logic                   write_en,
  input  mips_isa_pkg::reg_idx_t rs_idx,
  input  mips_isa_pkg::reg_idx_t rt_idx,
  input  mips_isa_pkg::reg_idx_t write_idx,
  input  mips_isa_pkg::word_t    write_data,
  output mips_isa_pkg::word_t    rs_value,
  output mips_isa_pkg::word_t    rt_value,
  output mips_isa_pkg::word_t    register_v0
);
  import mips_isa_pkg::*;

  word_t regs [32];

  // $zero is never written, so its entry stays cleared
  assign rs_value    = (rs_idx == '0) ? '0 : regs[rs_idx];
  assign rt_value    = (rt_idx == '0) ? '0 : regs[rt_idx];
  assign register_v0 = regs[REG_V0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (clk_enable && write_en && (write_idx != '0)) begin
      regs[write_idx] <= write_data;
    end
  end

endmodule

//--- hdl/mips_decode.sv
module mips_decode (
  input  mips_isa_pkg::word_t       instr,
  output mips_ctrl_pkg::alu_op_t    alu_op,
  output logic                      alu_src_imm,
  output logic                      reg_write,
  output logic                      mem_read,
  output logic                      mem_write,
  output logic                      hilo_write,
  output mips_ctrl_pkg::wb_sel_t    wb_sel,
  output mips_ctrl_pkg::mem_size_t  mem_size,
  output mips_ctrl_pkg::pc_sel_t    pc_sel,
  output mips_isa_pkg::reg_idx_t    dest_reg,
  output mips_isa_pkg::reg_idx_t    rs_idx,
  output mips_isa_pkg::reg_idx_t    rt_idx,
  output mips_isa_pkg::shamt_t      shamt,
  output mips_isa_pkg::word_t       imm_ext
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  opcode_t  opcode;
  funct_t   funct;
  reg_idx_t rd_idx;
  logic     zero_ext;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rs_idx = instr[25:21];
  assign rt_idx = instr[20:16];
  assign rd_idx = instr[15:11];
  assign shamt  = instr[10:6];

  // Logical immediates are zero extended, everything else sign extended
  assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
  assign imm_ext  = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

  always_comb begin
    // Defaults form a no-op
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    reg_write   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    hilo_write  = 1'b0;
    wb_sel      = WB_ALU;
    mem_size    = MEM_WORD;
    pc_sel      = PC_SEQ;
    dest_reg    = rt_idx;

    case (opcode)
      OP_SPECIAL: begin
        dest_reg = rd_idx;
        case (funct)
          FN_SLL:   begin alu_op = ALU_SLL;  reg_write = 1'b1; end
          FN_SRL:   begin alu_op = ALU_SRL;  reg_write = 1'b1; end
          FN_SRA:   begin alu_op = ALU_SRA;  reg_write = 1'b1; end
          FN_ADDU:  begin alu_op = ALU_ADD;  reg_write = 1'b1; end
          FN_SUBU:  begin alu_op = ALU_SUB;  reg_write = 1'b1; end
          FN_AND:   begin alu_op = ALU_AND;  reg_write = 1'b1; end
          FN_OR:    begin alu_op = ALU_OR;   reg_write = 1'b1; end
          FN_XOR:   begin alu_op = ALU_XOR;  reg_write = 1'b1; end
          FN_SLT:   begin alu_op = ALU_SLT;  reg_write = 1'b1; end
          FN_SLTU:  begin alu_op = ALU_SLTU; reg_write = 1'b1; end
          FN_MFHI:  begin wb_sel = WB_HI;    reg_write = 1'b1; end
          FN_MFLO:  begin wb_sel = WB_LO;    reg_write = 1'b1; end
          FN_MULTU: hilo_write = 1'b1;
          FN_JR:    pc_sel = PC_JREG;
          default:  ;
        endcase
      end
      OP_ADDIU: begin alu_op = ALU_ADD;  alu_src_imm = 1'b1; reg_write = 1'b1; end
      OP_ANDI:  begin alu_op = ALU_AND;  alu_src_imm = 1'b1; reg_write = 1'b1; end
      OP_ORI:   begin alu_op = ALU_OR;   alu_src_imm = 1'b1; reg_write = 1'b1; end
      OP_XORI:  begin alu_op = ALU_XOR;  alu_src_imm = 1'b1; reg_write = 1'b1; end
      OP_SLTI:  begin alu_op = ALU_SLT;  alu_src_imm = 1'b1; reg_write = 1'b1; end
      OP_LUI:   begin alu_op = ALU_LUI;  alu_src_imm = 1'b1; reg_write = 1'b1; end
      OP_LW, OP_LB, OP_LBU: begin
        alu_src_imm = 1'b1;
        mem_read    = 1'b1;
        reg_write   = 1'b1;
        wb_sel      = WB_LOAD;
        if (opcode == OP_LB) begin
          mem_size = MEM_BYTE_S;
        end else if (opcode == OP_LBU) begin
          mem_size = MEM_BYTE_U;
        end
      end
      OP_SW: begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      OP_SB: begin
        // Read too, so the other bytes of the word can be merged
        alu_src_imm = 1'b1;
        mem_read    = 1'b1;
        mem_write   = 1'b1;
        mem_size    = MEM_BYTE_U;
      end
      OP_BEQ, OP_BNE: pc_sel = PC_BRANCH;
      OP_J:           pc_sel = PC_JUMP;
      OP_JAL: begin
        pc_sel    = PC_JUMP;
        reg_write = 1'b1;
        wb_sel    = WB_LINK;
        dest_reg  = 5'd31;
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/mips_fetch.sv
module mips_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk_enable,
  input  logic                redirect,
  input  mips_isa_pkg::word_t target,
  output mips_isa_pkg::word_t pc,
  output logic                active
);
  import mips_isa_pkg::*;

  // Target waiting for the delay slot to retire
  logic  pending;
  word_t pending_target;
  word_t pc_next;

  always_comb begin
    if (pending) begin
      pc_next = pending_target;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= RESET_VECTOR;
      pending <= 1'b0;
      active  <= 1'b1;
    end else if (clk_enable && active) begin
      pc      <= pc_next;
      pending <= redirect;
      // Halt once the program has jumped to address 0
      if (pc_next == '0) begin
        active <= 1'b0;
      end
    end
  end

  // Target latched with the redirect request
  always_ff @(posedge clk) begin
    if (clk_enable && redirect) begin
      pending_target <= target;
    end
  end

  pc_aligned: assert property (
    @(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00
  ) else $error("fetch: pc %h not word aligned", pc);

endmodule

//--- hdl/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

  // ALU function picked by decode
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_t;

  // Source of the register write-back
  typedef enum logic [2:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK,
    WB_HI,
    WB_LO
  } wb_sel_t;

  // How the next PC is formed
  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JUMP,
    PC_JREG
  } pc_sel_t;

  typedef enum logic [1:0] {
    MEM_WORD,
    MEM_BYTE_S,
    MEM_BYTE_U
  } mem_size_t;

endpackage

//--- hdl/mips_isa_pkg.sv
package mips_isa_pkg;

  // Field widths of the MIPS-I encoding
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [4:0]  shamt_t;

  // Primary opcodes
  localparam opcode_t OP_SPECIAL = 6'h00;
  localparam opcode_t OP_J       = 6'h02;
  localparam opcode_t OP_JAL     = 6'h03;
  localparam opcode_t OP_BEQ     = 6'h04;
  localparam opcode_t OP_BNE     = 6'h05;
  localparam opcode_t OP_ADDIU   = 6'h09;
  localparam opcode_t OP_SLTI    = 6'h0a;
  localparam opcode_t OP_ANDI    = 6'h0c;
  localparam opcode_t OP_ORI     = 6'h0d;
  localparam opcode_t OP_XORI    = 6'h0e;
  localparam opcode_t OP_LUI     = 6'h0f;
  localparam opcode_t OP_LB      = 6'h20;
  localparam opcode_t OP_LW      = 6'h23;
  localparam opcode_t OP_LBU     = 6'h24;
  localparam opcode_t OP_SB      = 6'h28;
  localparam opcode_t OP_SW      = 6'h2b;

  // Function codes under OP_SPECIAL
  localparam funct_t FN_SLL   = 6'h00;
  localparam funct_t FN_SRL   = 6'h02;
  localparam funct_t FN_SRA   = 6'h03;
  localparam funct_t FN_JR    = 6'h08;
  localparam funct_t FN_MFHI  = 6'h10;
  localparam funct_t FN_MFLO  = 6'h12;
  localparam funct_t FN_MULTU = 6'h19;
  localparam funct_t FN_ADDU  = 6'h21;
  localparam funct_t FN_SUBU  = 6'h23;
  localparam funct_t FN_AND   = 6'h24;
  localparam funct_t FN_OR    = 6'h25;
  localparam funct_t FN_XOR   = 6'h26;
  localparam funct_t FN_SLT   = 6'h2a;
  localparam funct_t FN_SLTU  = 6'h2b;

  localparam word_t    RESET_VECTOR = 32'hbfc0_0000;
  localparam reg_idx_t REG_V0       = 5'd2;

endpackage
